// File: Makefile
# Verilator simulation of the MIPS pipeline testbench

VERILATOR ?= verilator
TOP       ?= mips_tb
BUILD     ?= build
FLAGS     ?= --binary --assert

.PHONY: sim clean

# Build, run, and pass only if the pass message is printed
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f files.f
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf $(BUILD)

// File: files.f
+incdir+hw
hw/mips_isa_pkg.sv
hw/mips_pipe_pkg.sv
hw/mips_regfile.sv
hw/mips_decoder.sv
hw/mips_operand_select.sv
hw/mips_pipe_reg.sv
hw/mips_execute.sv
hw/mips_core.sv
test/mips_assertions.sv
test/mips_tb.sv

// File: hw/mips_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_core (
  input  wire                      i_clk,
  input  wire                      i_arst_n,
  input  wire [`MIPS_XLEN-1:0]     i_instr,
  input  wire                      i_instr_valid,
  output logic                     o_result_valid,
  output logic [`MIPS_REG_AW-1:0]  o_result_reg,
  output logic [`MIPS_XLEN-1:0]    o_result_data,
  output logic                     o_halt
);

  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  logic                     accept;                  // Instruction taken this edge
  logic [`MIPS_REG_AW-1:0]  dec_rs, dec_rt, dec_dest;
  alu_op_e                  dec_alu_op;
  logic                     dec_use_imm, dec_reg_write, dec_is_halt;
  logic [`MIPS_XLEN-1:0]    dec_imm;
  logic [`MIPS_SHAMT_W-1:0] dec_shamt;
  logic [`MIPS_XLEN-1:0]    rs_data, rt_data;
  ex_req_t                  id_req, ex_req;
  wb_req_t                  ex_wb, wb_req;
  logic                     ex_valid, wb_valid;
  logic                     ex_wr, wb_wr;            // Writes qualified by valid

  assign accept = i_instr_valid && !o_halt;
  assign ex_wr  = ex_valid && ex_req.wr_en;
  assign wb_wr  = wb_valid && wb_req.wr_en;

  // Sticky until reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_halt <= 1'b0;
    end else if (accept && dec_is_halt) begin
      o_halt <= 1'b1;
    end
  end

  mips_regfile u_regfile (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_rs_addr (dec_rs),
    .i_rt_addr (dec_rt),
    .i_wr_en   (wb_wr),
    .i_wr_addr (wb_req.dest),
    .i_wr_data (wb_req.data),
    .o_rs_data (rs_data),
    .o_rt_data (rt_data)
  );

  mips_decoder u_decoder (
    .i_instr     (i_instr),
    .o_rs        (dec_rs),
    .o_rt        (dec_rt),
    .o_alu_op    (dec_alu_op),
    .o_use_imm   (dec_use_imm),
    .o_imm       (dec_imm),
    .o_shamt     (dec_shamt),
    .o_dest      (dec_dest),
    .o_reg_write (dec_reg_write),
    .o_is_halt   (dec_is_halt)
  );

  mips_operand_select u_opsel (
    .i_rs           (dec_rs),
    .i_rt           (dec_rt),
    .i_alu_op       (dec_alu_op),
    .i_use_imm      (dec_use_imm),
    .i_imm          (dec_imm),
    .i_shamt        (dec_shamt),
    .i_dest         (dec_dest),
    .i_reg_write    (dec_reg_write),
    .i_rs_data      (rs_data),
    .i_rt_data      (rt_data),
    .i_ex_dest      (ex_req.dest),           // Forward from execute
    .i_ex_reg_write (ex_wr),
    .i_ex_data      (ex_wb.data),
    .i_wb_dest      (wb_req.dest),           // Forward from write-back
    .i_wb_reg_write (wb_wr),
    .i_wb_data      (wb_req.data),
    .o_ex_req       (id_req)
  );

  // HALT enters as a bubble
  mips_pipe_reg #(.T(ex_req_t)) u_ex_reg (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (accept && !dec_is_halt),
    .i_data   (id_req),
    .o_valid  (ex_valid),
    .o_data   (ex_req)
  );

  mips_execute u_execute (
    .i_ex_req (ex_req),
    .o_wb_req (ex_wb)
  );

  mips_pipe_reg #(.T(wb_req_t)) u_wb_reg (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (ex_valid),
    .i_data   (ex_wb),
    .o_valid  (wb_valid),
    .o_data   (wb_req)
  );

  // Result seen in the write-back cycle, r0 writes included
  assign o_result_valid = wb_wr;
  assign o_result_reg   = wb_req.dest;
  assign o_result_data  = wb_req.data;

endmodule

`default_nettype wire

// File: hw/mips_decoder.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_decoder (
  input  wire [`MIPS_XLEN-1:0]     i_instr,
  output logic [`MIPS_REG_AW-1:0]  o_rs,
  output logic [`MIPS_REG_AW-1:0]  o_rt,
  output mips_isa_pkg::alu_op_e    o_alu_op,
  output logic                     o_use_imm,   // Operand B from immediate
  output logic [`MIPS_XLEN-1:0]    o_imm,
  output logic [`MIPS_SHAMT_W-1:0] o_shamt,
  output logic [`MIPS_REG_AW-1:0]  o_dest,
  output logic                     o_reg_write,
  output logic                     o_is_halt
);

  import mips_isa_pkg::*;

  logic [5:0]              opcode;
  logic [5:0]              funct;
  logic [`MIPS_REG_AW-1:0] rd;
  logic [15:0]             imm16;
  logic                    zext;    // Logic immediates are unsigned

  // Field split
  assign opcode  = i_instr[31:26];
  assign o_rs    = i_instr[25:21];
  assign o_rt    = i_instr[20:16];
  assign rd      = i_instr[15:11];
  assign o_shamt = i_instr[10:6];
  assign funct   = i_instr[5:0];
  assign imm16   = i_instr[15:0];

  assign o_is_halt = (i_instr == `MIPS_HALT_INSTR);

  // Every non-SPECIAL opcode kept here is I-type
  assign o_use_imm = (opcode != OPC_SPECIAL);
  assign o_dest    = o_use_imm ? o_rt : rd;   // rt for I-type, rd for R-type

  assign zext  = (opcode == OPC_ANDI) || (opcode == OPC_ORI) || (opcode == OPC_XORI);
  assign o_imm = (opcode == OPC_LUI) ? {imm16, 16'h0000} :
                 zext ? {{(`MIPS_XLEN-16){1'b0}}, imm16} :
                        {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

  always_comb begin
    o_alu_op    = ALU_ADD;
    o_reg_write = 1'b1;                       // Cleared below for unknowns
    case (opcode)
      OPC_SPECIAL: begin
        case (funct)
          FN_ADDU: o_alu_op = ALU_ADD;
          FN_SUBU: o_alu_op = ALU_SUB;
          FN_AND:  o_alu_op = ALU_AND;
          FN_OR:   o_alu_op = ALU_OR;
          FN_XOR:  o_alu_op = ALU_XOR;
          FN_NOR:  o_alu_op = ALU_NOR;
          FN_SLT:  o_alu_op = ALU_SLT;
          FN_SLL:  o_alu_op = ALU_SLL;
          FN_SRL:  o_alu_op = ALU_SRL;
          FN_SRA:  o_alu_op = ALU_SRA;
          default: o_reg_write = 1'b0;        // Unknown funct is a no-op
        endcase
      end
      OPC_ADDIU: o_alu_op = ALU_ADD;
      OPC_SLTI:  o_alu_op = ALU_SLT;
      OPC_ANDI:  o_alu_op = ALU_AND;
      OPC_ORI:   o_alu_op = ALU_OR;
      OPC_XORI:  o_alu_op = ALU_XOR;
      OPC_LUI:   o_alu_op = ALU_LUI;
      default:   o_reg_write = 1'b0;          // HALT and unknowns write nothing
    endcase
  end

endmodule

`default_nettype wire

// File: hw/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath widths
`define MIPS_XLEN        32             // Data word width
`define MIPS_REG_AW      5              // Register address width
`define MIPS_NUM_REGS    32             // Architectural register count
`define MIPS_SHAMT_W     5              // Shift amount field width

// Special encodings
`define MIPS_HALT_INSTR  32'hffff_ffff  // HALT, all ones

`endif

// File: hw/mips_execute.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_execute (
  input  wire mips_pipe_pkg::ex_req_t i_ex_req,
  output mips_pipe_pkg::wb_req_t      o_wb_req
);

  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  logic [`MIPS_XLEN-1:0] a, b;
  logic [`MIPS_XLEN-1:0] sum, diff;
  logic [`MIPS_XLEN-1:0] slt_res;
  logic [`MIPS_XLEN-1:0] sll_res, srl_res, sra_res;
  logic [`MIPS_XLEN-1:0] result;

  assign a = i_ex_req.opa;
  assign b = i_ex_req.opb;

  // All results in parallel
  assign sum     = a + b;
  assign diff    = a - b;
  assign slt_res = {{(`MIPS_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};  // Signed compare
  assign sll_res = b << i_ex_req.shamt;            // Shifts act on rt
  assign srl_res = b >> i_ex_req.shamt;
  assign sra_res = $signed(b) >>> i_ex_req.shamt;  // Sign fill

  always_comb begin
    case (i_ex_req.op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_NOR: result = ~(a | b);
      ALU_SLT: result = slt_res;
      ALU_SLL: result = sll_res;
      ALU_SRL: result = srl_res;
      ALU_SRA: result = sra_res;
      ALU_LUI: result = b;                       // Immediate already in upper half
      default: result = '0;
    endcase
  end

  always_comb begin
    o_wb_req.data  = result;
    o_wb_req.dest  = i_ex_req.dest;
    o_wb_req.wr_en = i_ex_req.wr_en;
  end

endmodule

`default_nettype wire

// File: hw/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

  // Primary opcode, bits 31:26
  typedef enum logic [5:0] {
    OPC_SPECIAL = 6'h00,  // R-type, funct selects
    OPC_ADDIU   = 6'h09,
    OPC_SLTI    = 6'h0a,  // Signed compare with immediate
    OPC_ANDI    = 6'h0c,  // Zero-extended immediate
    OPC_ORI     = 6'h0d,  // Zero-extended immediate
    OPC_XORI    = 6'h0e,  // Zero-extended immediate
    OPC_LUI     = 6'h0f   // Immediate into upper half
  } opcode_e;

  // R-type function code, bits 5:0
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a
  } funct_e;

  // Internal ALU operation
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
    ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLL,
    ALU_SRL, ALU_SRA, ALU_LUI
  } alu_op_e;

endpackage

`default_nettype wire

// File: hw/mips_operand_select.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_operand_select (
  input  wire [`MIPS_REG_AW-1:0]    i_rs,
  input  wire [`MIPS_REG_AW-1:0]    i_rt,
  input  wire mips_isa_pkg::alu_op_e i_alu_op,
  input  wire                       i_use_imm,
  input  wire [`MIPS_XLEN-1:0]      i_imm,
  input  wire [`MIPS_SHAMT_W-1:0]   i_shamt,
  input  wire [`MIPS_REG_AW-1:0]    i_dest,
  input  wire                       i_reg_write,
  input  wire [`MIPS_XLEN-1:0]      i_rs_data,       // Register file port A
  input  wire [`MIPS_XLEN-1:0]      i_rt_data,       // Register file port B
  input  wire [`MIPS_REG_AW-1:0]    i_ex_dest,       // Execute step
  input  wire                       i_ex_reg_write,
  input  wire [`MIPS_XLEN-1:0]      i_ex_data,
  input  wire [`MIPS_REG_AW-1:0]    i_wb_dest,       // Write-back step
  input  wire                       i_wb_reg_write,
  input  wire [`MIPS_XLEN-1:0]      i_wb_data,
  output mips_pipe_pkg::ex_req_t    o_ex_req
);

  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  logic                  ex_hit_rs, wb_hit_rs;
  logic                  ex_hit_rt, wb_hit_rt;
  logic [`MIPS_XLEN-1:0] rs_val, rt_val;

  // Source matches, r0 never forwarded
  assign ex_hit_rs = i_ex_reg_write && (i_ex_dest == i_rs) && (i_rs != '0);
  assign wb_hit_rs = i_wb_reg_write && (i_wb_dest == i_rs) && (i_rs != '0);
  assign ex_hit_rt = i_ex_reg_write && (i_ex_dest == i_rt) && (i_rt != '0);
  assign wb_hit_rt = i_wb_reg_write && (i_wb_dest == i_rt) && (i_rt != '0);

  // Newest value wins, execute then write-back then file
  assign rs_val = ex_hit_rs ? i_ex_data :
                  wb_hit_rs ? i_wb_data : i_rs_data;
  assign rt_val = ex_hit_rt ? i_ex_data :
                  wb_hit_rt ? i_wb_data : i_rt_data;

  always_comb begin
    o_ex_req.op    = i_alu_op;
    o_ex_req.opa   = rs_val;
    o_ex_req.opb   = i_use_imm ? i_imm : rt_val;  // Immediate or rt
    o_ex_req.shamt = i_shamt;
    o_ex_req.dest  = i_dest;
    o_ex_req.wr_en = i_reg_write;
  end

endmodule

`default_nettype wire

// File: hw/mips_pipe_pkg.sv
`default_nettype none
`include "mips_defines.svh"

package mips_pipe_pkg;

  // Decode and read to execute
  typedef struct packed {
    mips_isa_pkg::alu_op_e         op;     // Operation to perform
    logic [`MIPS_XLEN-1:0]         opa;    // Forwarded rs value
    logic [`MIPS_XLEN-1:0]         opb;    // Forwarded rt or immediate
    logic [`MIPS_SHAMT_W-1:0]      shamt;  // Shift amount field
    logic [`MIPS_REG_AW-1:0]       dest;   // Destination register
    logic                          wr_en;  // Writes the register file
  } ex_req_t;

  // Execute to write-back
  typedef struct packed {
    logic [`MIPS_XLEN-1:0]         data;   // ALU result
    logic [`MIPS_REG_AW-1:0]       dest;   // Destination register
    logic                          wr_en;  // Writes the register file
  } wb_req_t;

endpackage

`default_nettype wire

// File: hw/mips_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module mips_pipe_reg #(
  parameter type T = logic [31:0]   // Payload carried between steps
) (
  input  wire   i_clk,
  input  wire   i_arst_n,
  input  wire   i_valid,
  input  wire T i_data,
  output logic  o_valid,
  output T      o_data
);

  // Valid flag is control state
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // Payload holds its last valid value
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/mips_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_regfile (
  input  wire                      i_clk,
  input  wire                      i_arst_n,
  input  wire [`MIPS_REG_AW-1:0]   i_rs_addr,   // Read port A
  input  wire [`MIPS_REG_AW-1:0]   i_rt_addr,   // Read port B
  input  wire                      i_wr_en,
  input  wire [`MIPS_REG_AW-1:0]   i_wr_addr,
  input  wire [`MIPS_XLEN-1:0]     i_wr_data,
  output logic [`MIPS_XLEN-1:0]    o_rs_data,
  output logic [`MIPS_XLEN-1:0]    o_rt_data
);

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];  // Register array
  logic                  wr_ok;                  // Write allowed, never r0

  assign wr_ok = i_wr_en && (i_wr_addr != '0);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;                           // Whole file clears
      end
    end else if (wr_ok) begin
      regs[i_wr_addr] <= i_wr_data;              // Write on edge N+2
    end
  end

  // Asynchronous reads, r0 stays zero since never written
  assign o_rs_data = regs[i_rs_addr];
  assign o_rt_data = regs[i_rt_addr];

endmodule

`default_nettype wire

// File: test/mips_assertions.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_assertions (
  input wire                  i_clk,
  input wire                  i_arst_n,
  input wire                  i_result_valid,
  input wire [`MIPS_XLEN-1:0] i_result_data,
  input wire                  i_halt
);

  // Halt is sticky until reset
  halt_sticky: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_halt |=> i_halt)
    else $error("o_halt fell without a reset");

  // In-flight work drains within two cycles of halt
  quiet_after_halt: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_halt && $past(i_halt, 2)) |-> !i_result_valid)
    else $error("o_result_valid high long after o_halt was set");

  // Reported data is always known
  known_result: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_result_valid |-> !$isunknown(i_result_data))
    else $error("o_result_data unknown while o_result_valid is high");

endmodule

bind mips_core mips_assertions u_assertions (
  .i_clk          (i_clk),
  .i_arst_n       (i_arst_n),
  .i_result_valid (o_result_valid),
  .i_result_data  (o_result_data),
  .i_halt         (o_halt)
);

`default_nettype wire

// File: test/mips_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "mips_defines.svh"

module mips_tb;

  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;

  localparam int PERIOD     = 20;                 // Clock period in ns
  localparam int N_INSTR    = 400;                // Random slots before HALT
  localparam int POST_HALT  = 10;                 // Slots driven after HALT
  localparam int DRAIN      = 6;                  // Idle slots at the end
  localparam int TIMEOUT_NS = (N_INSTR + POST_HALT + DRAIN + 20) * PERIOD * 2;
  localparam int K_NOOP     = 16;                 // Kinds 0..9 R-type, 10..15 I-type

  logic                    clk = 1'b0;
  logic                    arst_n;
  logic [`MIPS_XLEN-1:0]   instr;
  logic                    instr_valid;
  logic                    result_valid;
  logic [`MIPS_REG_AW-1:0] result_reg;
  logic [`MIPS_XLEN-1:0]   result_data;
  logic                    halt;

  integer                seed;                    // Shared random state
  logic [`MIPS_XLEN-1:0] mregs [8];               // Model registers r0..r7
  bit                    model_halt;
  int                    cycle;                   // Falling edges since reset release
  int                    errors;
  int                    checks;
  wb_req_t               exp_q [$];               // Expected results in order
  int                    due_q [$];               // Falling edge where each is seen

  mips_core DUT (
    .i_clk          (clk),
    .i_arst_n       (arst_n),
    .i_instr        (instr),
    .i_instr_valid  (instr_valid),
    .o_result_valid (result_valid),
    .o_result_reg   (result_reg),
    .o_result_data  (result_data),
    .o_halt         (halt)
  );

  always #(PERIOD / 2) clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % 32'(n));
  endfunction

  function automatic logic [31:0] rtype(input logic [5:0] funct, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, funct};
  endfunction

  function automatic logic [31:0] itype(input logic [5:0] opc, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {opc, rs, rt, imm};
  endfunction

  // Instruction word for one kind
  function automatic logic [31:0] encode(input int kind, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [4:0] rd,
                                         input logic [4:0] sh, input logic [15:0] imm);
    case (kind)
      0:       return rtype(FN_ADDU, rs, rt, rd, 5'd0);
      1:       return rtype(FN_SUBU, rs, rt, rd, 5'd0);
      2:       return rtype(FN_AND, rs, rt, rd, 5'd0);
      3:       return rtype(FN_OR, rs, rt, rd, 5'd0);
      4:       return rtype(FN_XOR, rs, rt, rd, 5'd0);
      5:       return rtype(FN_NOR, rs, rt, rd, 5'd0);
      6:       return rtype(FN_SLT, rs, rt, rd, 5'd0);
      7:       return rtype(FN_SLL, 5'd0, rt, rd, sh);   // Shifts take rt only
      8:       return rtype(FN_SRL, 5'd0, rt, rd, sh);
      9:       return rtype(FN_SRA, 5'd0, rt, rd, sh);
      10:      return itype(OPC_ADDIU, rs, rt, imm);
      11:      return itype(OPC_SLTI, rs, rt, imm);
      12:      return itype(OPC_ANDI, rs, rt, imm);
      13:      return itype(OPC_ORI, rs, rt, imm);
      14:      return itype(OPC_XORI, rs, rt, imm);
      15:      return itype(OPC_LUI, 5'd0, rt, imm);
      default: return itype(6'h23, rs, rt, imm);        // Load opcode, dropped here
    endcase
  endfunction

  // Architectural result of one kind
  function automatic logic [31:0] model_result(input int kind, input logic [31:0] a,
                                               input logic [31:0] b, input logic [15:0] imm,
                                               input logic [4:0] sh);
    logic [31:0] se;
    logic [31:0] ze;
    se = {{16{imm[15]}}, imm};
    ze = {16'h0000, imm};
    case (kind)
      0:       return a + b;
      1:       return a - b;
      2:       return a & b;
      3:       return a | b;
      4:       return a ^ b;
      5:       return ~(a | b);
      6:       return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      7:       return b << sh;
      8:       return b >> sh;
      9:       return 32'($signed(b) >>> sh);
      10:      return a + se;
      11:      return ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
      12:      return a & ze;
      13:      return a | ze;
      14:      return a ^ ze;
      15:      return {imm, 16'h0000};
      default: return 32'h0;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Next falling edge, then compare outputs before new drive
  task automatic next_cycle();
    wb_req_t e;
    @(negedge clk);
    cycle++;
    if (due_q.size() > 0 && due_q[0] == cycle) begin
      e = exp_q.pop_front();
      void'(due_q.pop_front());
      check_value("o_result_valid", 32'(result_valid), 32'd1);
      check_value("o_result_reg", 32'(result_reg), 32'(e.dest));
      check_value("o_result_data", result_data, e.data);
    end else begin
      check_value("o_result_valid", 32'(result_valid), 32'd0);  // Idle or no-op slot
    end
    check_value("o_halt", 32'(halt), 32'(model_halt));
  endtask

  task automatic send_idle();
    next_cycle();
    instr_valid = 1'b0;
    instr       = 32'(rand_below(65536));              // Junk on an idle bus
  endtask

  task automatic send_random();
    int          kind;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  sh;
    logic [15:0] imm;
    logic [4:0]  dest;
    logic [31:0] res;
    wb_req_t     e;
    next_cycle();
    kind = rand_below(K_NOOP + 1);
    rs   = 5'(rand_below(8));                          // r0..r7 forces dependencies
    rt   = 5'(rand_below(8));
    rd   = 5'(rand_below(8));
    sh   = 5'(rand_below(32));
    imm  = 16'(rand_below(65536));
    instr       = encode(kind, rs, rt, rd, sh, imm);
    instr_valid = 1'b1;
    if (!model_halt && kind != K_NOOP) begin
      res  = model_result(kind, mregs[rs[2:0]], mregs[rt[2:0]], imm, sh);
      dest = (kind < 10) ? rd : rt;
      e.data  = res;
      e.dest  = dest;
      e.wr_en = 1'b1;
      exp_q.push_back(e);
      due_q.push_back(cycle + 2);                      // Seen two edges after acceptance
      if (dest != 5'd0) begin
        mregs[dest[2:0]] = res;                        // r0 reported but stays zero
      end
    end
  endtask

  task automatic send_halt();
    next_cycle();
    instr       = `MIPS_HALT_INSTR;
    instr_valid = 1'b1;
    model_halt  = 1'b1;
  endtask

  initial begin
    arst_n      = 1'b0;
    instr       = '0;
    instr_valid = 1'b0;
    seed        = 32'hf692_b941;
    model_halt  = 1'b0;
    cycle       = 0;
    errors      = 0;
    checks      = 0;
    for (int i = 0; i < 8; i++) begin
      mregs[i] = '0;
    end
    repeat (2) @(negedge clk);                         // Two rising edges in reset
    arst_n = 1'b1;
    for (int i = 0; i < N_INSTR; i++) begin
      if (rand_below(5) == 0) begin
        send_idle();
      end else begin
        send_random();
      end
    end
    send_halt();
    for (int i = 0; i < POST_HALT; i++) begin
      send_random();                                   // Refused by the halted core
    end
    for (int i = 0; i < DRAIN; i++) begin
      send_idle();
    end
    check_value("results still pending", 32'(exp_q.size()), 32'd0);
    $display("Finished: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the stream did not complete within %0d ns", TIMEOUT_NS);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire
